// File: common/matcalc_pkg.sv
// shared sizes, element and matrix types and enums for the matrix calculator core, import with ::*
`default_nettype none

package matcalc_pkg;

	// ==============================
	// sizes
	// ==============================
	localparam int MAX_DIM    = 5;                   // rows or cols, 1..5
	localparam int MAX_ELEMS  = MAX_DIM * MAX_DIM;   // 25 per buffer
	localparam int ELEM_W     = 8;                   // operand element
	localparam int RES_W      = 16;                  // widened result element
	localparam int DIM_W      = 3;
	localparam int IDX_W      = $clog2(MAX_ELEMS);   // flat row-major index, 5 bits
	localparam int SCALAR_MAX = 9;                   // legal scalar 0..9

	// ==============================
	// data types
	// ==============================
	typedef logic [ELEM_W-1:0] elem_t;
	typedef logic [RES_W-1:0]  res_t;
	typedef logic [DIM_W-1:0]  dim_t;

	// element 0 is row 0 col 0, then row-major
	typedef logic [MAX_ELEMS-1:0][ELEM_W-1:0] elem_mat_t;   // 200 bits
	typedef logic [MAX_ELEMS-1:0][RES_W-1:0]  res_mat_t;    // 400 bits

	// ==============================
	// encodings
	// ==============================
	typedef enum logic [1:0] {
		OP_TRANSPOSE = 2'd0,
		OP_SCALAR    = 2'd1,
		OP_ADD       = 2'd2,
		OP_MULTIPLY  = 2'd3
	} op_e;

	typedef enum logic [1:0] {
		ST_OK         = 2'd0,
		ST_DIM_ERR    = 2'd1,   // add size mismatch or inner dims differ
		ST_SCALAR_ERR = 2'd2    // scalar above SCALAR_MAX
	} status_e;

	// command controller states
	typedef enum logic [2:0] {
		IDLE   = 3'd0,
		CHECK  = 3'd1,   // scalar and dimension checks
		RUN_EW = 3'd2,   // elementwise branch busy
		RUN_MM = 3'd3,   // multiply branch busy
		STREAM = 3'd4,   // result going out
		REPORT = 3'd5    // done pulse, status valid
	} calc_state_e;

endpackage

`default_nettype wire

// File: rtl/operand_store.sv
// holds operand matrices A and B, filled element by element from the load stream
`timescale 1ns/1ps
`default_nettype none

module operand_store import matcalc_pkg::*; (
	input  wire       clk,
	input  wire       rst_n,
	input  wire       ld_valid,
	input  wire       ld_slot,     // 0 = A, 1 = B
	input  wire       ld_first,    // first element, dims sampled here
	input  dim_t      ld_m,
	input  dim_t      ld_n,
	input  elem_t     ld_data,
	input  wire       busy,
	output logic      ld_ready,
	output elem_mat_t mat_a,
	output elem_mat_t mat_b,
	output dim_t      m_a,
	output dim_t      n_a,
	output dim_t      m_b,
	output dim_t      n_b
);

	logic             rdy_q;    // low for one cycle out of reset
	logic [IDX_W-1:0] wr_idx;   // next position in the slot
	logic             ld_acc;   // element taken this cycle
	logic             idx_ok;

	assign ld_ready = rdy_q & ~busy;   // operands frozen during a command
	assign ld_acc   = ld_valid & ld_ready;
	assign idx_ok   = (wr_idx < IDX_W'(MAX_ELEMS));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= 1'b1;
		end
	end

	// write index and latched dimensions
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_idx <= '0;
			m_a    <= '0;
			n_a    <= '0;
			m_b    <= '0;
			n_b    <= '0;
		end else if (ld_acc) begin
			if (ld_first) begin
				wr_idx <= IDX_W'(1);   // element 0 goes in with the header
				if (ld_slot) begin
					m_b <= ld_m;
					n_b <= ld_n;
				end else begin
					m_a <= ld_m;
					n_a <= ld_n;
				end
			end else if (idx_ok) begin
				wr_idx <= wr_idx + 1'b1;
			end
		end
	end

	// slot buffers
	// whole slot zeroed on ld_first so a smaller matrix leaves no stale tail
	always_ff @(posedge clk) begin
		if (ld_acc && !ld_slot) begin
			if (ld_first) begin
				mat_a    <= '0;
				mat_a[0] <= ld_data;   // later nba wins over the clear
			end else if (idx_ok) begin
				mat_a[wr_idx] <= ld_data;
			end
		end
		if (ld_acc && ld_slot) begin
			if (ld_first) begin
				mat_b    <= '0;
				mat_b[0] <= ld_data;
			end else if (idx_ok) begin
				mat_b[wr_idx] <= ld_data;
			end
		end
	end

endmodule

`default_nettype wire

// File: alu/calc_ctrl.sv
// command FSM, checks the operands, runs one compute branch then the stream, reports status
`timescale 1ns/1ps
`default_nettype none

module calc_ctrl import matcalc_pkg::*; (
	input  wire     clk,
	input  wire     rst_n,
	input  wire     start,      // one-cycle pulse
	input  op_e     op,
	input  elem_t   scalar,
	input  dim_t    m_a,
	input  dim_t    n_a,
	input  dim_t    m_b,
	input  dim_t    n_b,
	input  wire     ew_done,
	input  wire     mm_done,
	input  wire     st_done,
	output logic    ew_start,
	output logic    mm_start,
	output logic    st_start,
	output logic    st_sel,     // 0 = elementwise, 1 = multiply
	output logic    busy,
	output logic    done,
	output status_e status,
	output op_e     op_q,       // latched command for the units
	output elem_t   scalar_q
);

	calc_state_e state;
	status_e     chk_status;

	// ==============================
	// operand checks, priority order
	// ==============================
	always_comb begin
		chk_status = ST_OK;
		if (op_q == OP_SCALAR && scalar_q > elem_t'(SCALAR_MAX)) begin
			chk_status = ST_SCALAR_ERR;
		end else if (op_q == OP_ADD && (m_a != m_b || n_a != n_b)) begin
			chk_status = ST_DIM_ERR;
		end else if (op_q == OP_MULTIPLY && n_a != m_b) begin
			chk_status = ST_DIM_ERR;   // inner dims must agree
		end
	end

	// busy drops in REPORT, together with the done pulse
	assign busy = (state == CHECK) || (state == RUN_EW) ||
	              (state == RUN_MM) || (state == STREAM);
	assign done = (state == REPORT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= IDLE;
			ew_start <= 1'b0;
			mm_start <= 1'b0;
			st_start <= 1'b0;
			st_sel   <= 1'b0;
			status   <= ST_OK;
			op_q     <= OP_TRANSPOSE;
			scalar_q <= '0;
		end else begin
			ew_start <= 1'b0;   // pulses
			mm_start <= 1'b0;
			st_start <= 1'b0;
			case (state)
				IDLE, REPORT: begin
					state <= IDLE;
					if (start) begin   // not busy here, so start is taken
						op_q     <= op;
						scalar_q <= scalar;
						state    <= CHECK;
					end
				end
				CHECK: begin
					status <= chk_status;
					if (chk_status != ST_OK) begin
						state <= REPORT;   // error path, no result stream
					end else if (op_q == OP_MULTIPLY) begin
						state    <= RUN_MM;
						mm_start <= 1'b1;
						st_sel   <= 1'b1;
					end else begin
						state    <= RUN_EW;
						ew_start <= 1'b1;
						st_sel   <= 1'b0;
					end
				end
				RUN_EW: begin
					if (ew_done) begin
						state    <= STREAM;
						st_start <= 1'b1;
					end
				end
				RUN_MM: begin
					if (mm_done) begin
						state    <= STREAM;
						st_start <= 1'b1;
					end
				end
				STREAM: begin
					if (st_done) state <= REPORT;   // last element went out
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: alu/elementwise_unit.sv
// transpose, scalar multiply and add of whole matrices, one registered step per ew_start
`timescale 1ns/1ps
`default_nettype none

module elementwise_unit import matcalc_pkg::*; (
	input  wire       clk,
	input  wire       rst_n,
	input  wire       ew_start,
	input  op_e       op_q,
	input  elem_t     scalar_q,
	input  elem_mat_t mat_a,
	input  elem_mat_t mat_b,
	input  dim_t      m_a,
	input  dim_t      n_a,
	output logic      ew_done,
	output res_mat_t  ew_res,
	output dim_t      ew_m,
	output dim_t      ew_n
);

	res_mat_t ew_next;

	// ==============================
	// combinational result
	// ==============================
	always_comb begin
		ew_next = '0;
		case (op_q)
			OP_TRANSPOSE: begin
				// a[i][j] lands at row j col i of the n x m result
				for (int i = 0; i < MAX_DIM; i++) begin
					for (int j = 0; j < MAX_DIM; j++) begin
						if (i < m_a && j < n_a) begin
							ew_next[j * m_a + i] = res_t'(mat_a[i * n_a + j]);
						end
					end
				end
			end
			OP_SCALAR: begin
				for (int k = 0; k < MAX_ELEMS; k++) begin
					ew_next[k] = res_t'(mat_a[k]) * res_t'(scalar_q);   // unused slots are 0
				end
			end
			OP_ADD: begin
				for (int k = 0; k < MAX_ELEMS; k++) begin
					ew_next[k] = res_t'(mat_a[k]) + res_t'(mat_b[k]);
				end
			end
			default: ew_next = '0;   // multiply lives in the other branch
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ew_done <= 1'b0;
		end else begin
			ew_done <= ew_start;   // one cycle after start
		end
	end

	// result payload and its dimensions
	always_ff @(posedge clk) begin
		if (ew_start) begin
			ew_res <= ew_next;
			ew_m   <= (op_q == OP_TRANSPOSE) ? n_a : m_a;   // transpose swaps dims
			ew_n   <= (op_q == OP_TRANSPOSE) ? m_a : n_a;
		end
	end

endmodule

`default_nettype wire

// File: alu/matmul_unit.sv
// sequential matrix product, one multiply-accumulate per cycle into a result buffer
`timescale 1ns/1ps
`default_nettype none

module matmul_unit import matcalc_pkg::*; (
	input  wire       clk,
	input  wire       rst_n,
	input  wire       mm_start,
	input  elem_mat_t mat_a,
	input  elem_mat_t mat_b,
	input  dim_t      m_a,
	input  dim_t      n_a,       // also rows of B
	input  dim_t      n_b,
	output logic      mm_done,
	output res_mat_t  mm_res,
	output dim_t      mm_m,
	output dim_t      mm_n
);

	logic             running;
	dim_t             row, col, inner;
	res_t             acc;       // partial dot product
	res_t             sum;
	logic [IDX_W-1:0] a_idx, b_idx, r_idx;
	logic             inner_last, col_last, row_last;

	// flat row-major indices
	assign a_idx = IDX_W'(row) * IDX_W'(n_a) + IDX_W'(inner);
	assign b_idx = IDX_W'(inner) * IDX_W'(n_b) + IDX_W'(col);
	assign r_idx = IDX_W'(row) * IDX_W'(n_b) + IDX_W'(col);

	assign sum = acc + res_t'(mat_a[a_idx]) * res_t'(mat_b[b_idx]);

	assign inner_last = (inner == n_a - 3'd1);
	assign col_last   = (col == n_b - 3'd1);
	assign row_last   = (row == m_a - 3'd1);

	// ==============================
	// counters and accumulator
	// ==============================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			mm_done <= 1'b0;
			row     <= '0;
			col     <= '0;
			inner   <= '0;
			acc     <= '0;
		end else begin
			mm_done <= 1'b0;
			if (mm_start) begin
				running <= 1'b1;
				row     <= '0;
				col     <= '0;
				inner   <= '0;
				acc     <= '0;
			end else if (running) begin
				if (!inner_last) begin
					inner <= inner + 3'd1;
					acc   <= sum;
				end else begin
					inner <= '0;
					acc   <= '0;   // dot product written below
					if (!col_last) begin
						col <= col + 3'd1;
					end else begin
						col <= '0;
						if (row_last) begin
							running <= 1'b0;
							mm_done <= 1'b1;   // after the last element
						end else begin
							row <= row + 3'd1;
						end
					end
				end
			end
		end
	end

	// result buffer, m_a x n_b
	always_ff @(posedge clk) begin
		if (mm_start) begin
			mm_m <= m_a;
			mm_n <= n_b;
		end
		if (running && inner_last) mm_res[r_idx] <= sum;
	end

endmodule

`default_nettype wire

// File: alu/result_streamer.sv
// picks the finished branch result and streams it out row-major under res_ready back-pressure
`timescale 1ns/1ps
`default_nettype none

module result_streamer import matcalc_pkg::*; (
	input  wire      clk,
	input  wire      rst_n,
	input  wire      st_start,
	input  wire      st_sel,      // 0 = elementwise, 1 = multiply
	input  res_mat_t ew_res,
	input  res_mat_t mm_res,
	input  dim_t     ew_m,
	input  dim_t     ew_n,
	input  dim_t     mm_m,
	input  dim_t     mm_n,
	input  wire      res_ready,
	output logic     res_valid,
	output res_t     res_data,
	output logic     res_last,
	output dim_t     res_m,
	output dim_t     res_n,
	output logic     st_done
);

	res_mat_t         buf_q;     // latched result
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] total;
	logic             xfer;

	assign total    = IDX_W'(res_m) * IDX_W'(res_n);
	assign res_data = buf_q[rd_idx];   // registered source, stable while stalled
	assign res_last = (rd_idx == total - 1'b1);
	assign xfer     = res_valid & res_ready;
	assign st_done  = xfer & res_last;   // fires with the final transfer

	// ==============================
	// stream control
	// ==============================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
			rd_idx    <= '0;
		end else if (st_start) begin
			res_valid <= 1'b1;
			rd_idx    <= '0;
		end else if (xfer) begin
			if (res_last) begin
				res_valid <= 1'b0;
			end else begin
				rd_idx <= rd_idx + 1'b1;
			end
		end
	end

	// selected branch, held until the next st_start
	always_ff @(posedge clk) begin
		if (st_start) begin
			buf_q <= st_sel ? mm_res : ew_res;
			res_m <= st_sel ? mm_m : ew_m;
			res_n <= st_sel ? mm_n : ew_n;
		end
	end

endmodule

`default_nettype wire

// File: rtl/matrix_calc_top.sv
// matrix calculator core top, load stream in, start/busy/done command, result stream out
`timescale 1ns/1ps
`default_nettype none

module matrix_calc_top import matcalc_pkg::*; (
	input  wire     clk,
	input  wire     rst_n,
	// load stream
	input  wire     ld_valid,
	input  wire     ld_slot,
	input  wire     ld_first,
	input  dim_t    ld_m,
	input  dim_t    ld_n,
	input  elem_t   ld_data,
	output logic    ld_ready,
	// command
	input  wire     start,
	input  op_e     op,
	input  elem_t   scalar,
	output logic    busy,
	output logic    done,
	output status_e status,
	// result stream
	output logic    res_valid,
	output res_t    res_data,
	output logic    res_last,
	output dim_t    res_m,
	output dim_t    res_n,
	input  wire     res_ready
);

	elem_mat_t mat_a, mat_b;
	dim_t      m_a, n_a, m_b, n_b;
	op_e       op_q;
	elem_t     scalar_q;
	logic      ew_start, ew_done;
	logic      mm_start, mm_done;
	logic      st_start, st_sel, st_done;
	res_mat_t  ew_res, mm_res;
	dim_t      ew_m, ew_n, mm_m, mm_n;

	// ==============================
	// operand side
	// ==============================
	operand_store u_store (
		.clk(clk), .rst_n(rst_n),
		.ld_valid(ld_valid), .ld_slot(ld_slot), .ld_first(ld_first),
		.ld_m(ld_m), .ld_n(ld_n), .ld_data(ld_data),
		.busy(busy), .ld_ready(ld_ready),
		.mat_a(mat_a), .mat_b(mat_b),
		.m_a(m_a), .n_a(n_a), .m_b(m_b), .n_b(n_b)
	);

	calc_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n),
		.start(start), .op(op), .scalar(scalar),
		.m_a(m_a), .n_a(n_a), .m_b(m_b), .n_b(n_b),
		.ew_done(ew_done), .mm_done(mm_done), .st_done(st_done),
		.ew_start(ew_start), .mm_start(mm_start),
		.st_start(st_start), .st_sel(st_sel),
		.busy(busy), .done(done), .status(status),
		.op_q(op_q), .scalar_q(scalar_q)
	);

	// ==============================
	// compute branches and output
	// ==============================
	elementwise_unit u_ew (
		.clk(clk), .rst_n(rst_n),
		.ew_start(ew_start), .op_q(op_q), .scalar_q(scalar_q),
		.mat_a(mat_a), .mat_b(mat_b), .m_a(m_a), .n_a(n_a),
		.ew_done(ew_done), .ew_res(ew_res), .ew_m(ew_m), .ew_n(ew_n)
	);

	matmul_unit u_mm (
		.clk(clk), .rst_n(rst_n),
		.mm_start(mm_start), .mat_a(mat_a), .mat_b(mat_b),
		.m_a(m_a), .n_a(n_a), .n_b(n_b),
		.mm_done(mm_done), .mm_res(mm_res), .mm_m(mm_m), .mm_n(mm_n)
	);

	result_streamer u_stream (
		.clk(clk), .rst_n(rst_n),
		.st_start(st_start), .st_sel(st_sel),
		.ew_res(ew_res), .mm_res(mm_res),
		.ew_m(ew_m), .ew_n(ew_n), .mm_m(mm_m), .mm_n(mm_n),
		.res_ready(res_ready), .res_valid(res_valid), .res_data(res_data),
		.res_last(res_last), .res_m(res_m), .res_n(res_n), .st_done(st_done)
	);

endmodule

`default_nettype wire

// File: bench/tb_matrix_calc.sv
// testbench for matrix_calc_top, replays the stim file and checks status, dims and every result element
`timescale 1ns/1ps
`default_nettype none

module tb_matrix_calc import matcalc_pkg::*; ();

	localparam int    CLK_PERIOD = 10;     // ns
	localparam int    RST_CYCLES = 16;
	localparam int    WORST_CYC  = 600;    // 5x5 multiply plus a stalled stream, with margin
	localparam string STIM_FILE  = "bench/matcalc_stim.txt";

	logic    clk;
	logic    rst_n;
	logic    ld_valid;
	logic    ld_slot;
	logic    ld_first;
	dim_t    ld_m;
	dim_t    ld_n;
	elem_t   ld_data;
	logic    ld_ready;
	logic    start;
	op_e     op;
	elem_t   scalar;
	logic    busy;
	logic    done;
	status_e status;
	logic    res_valid;
	res_t    res_data;
	logic    res_last;
	dim_t    res_m;
	dim_t    res_n;
	logic    res_ready;

	int          tok_q[$];   // parsed stim values, record after record
	int          rec_cnt;
	logic        parsed;
	logic [31:0] lcg_state;

	matrix_calc_top DUT (
		.clk(clk), .rst_n(rst_n),
		.ld_valid(ld_valid), .ld_slot(ld_slot), .ld_first(ld_first),
		.ld_m(ld_m), .ld_n(ld_n), .ld_data(ld_data), .ld_ready(ld_ready),
		.start(start), .op(op), .scalar(scalar),
		.busy(busy), .done(done), .status(status),
		.res_valid(res_valid), .res_data(res_data), .res_last(res_last),
		.res_m(res_m), .res_n(res_n), .res_ready(res_ready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ==============================
	// helpers and compare tasks
	// ==============================
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_status(input string name, input status_e got, input status_e exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic check_dim(input string name, input dim_t got, input dim_t exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic check_res(input string name, input res_t got, input res_t exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch %s: got 0x%04h expected 0x%04h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// ==============================
	// stim file parsing
	// ==============================
	task automatic read_stim();
		int    fd;
		int    code;
		int    nhdr;
		int    nel;
		int    i;
		int    hdr[5];
		string tok;
		string line;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) abort_run("cannot open the stim file bench/matcalc_stim.txt");
		rec_cnt = 0;
		forever begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1) break;   // end of file
			if (tok == "#") begin
				code = $fgets(line, fd);   // skip comment text
			end else if (tok == "L" || tok == "C") begin
				nhdr = (tok == "L") ? 3 : 5;   // slot m n | op scalar status m n
				tok_q.push_back((tok == "L") ? 0 : 1);
				for (i = 0; i < nhdr; i++) begin
					code = $fscanf(fd, "%h", hdr[i]);
					if (code != 1) abort_run("stim file ends inside a record header");
					tok_q.push_back(hdr[i]);
				end
				nel = hdr[nhdr-2] * hdr[nhdr-1];   // m*n elements follow
				for (i = 0; i < nel; i++) begin
					code = $fscanf(fd, "%h", hdr[0]);
					if (code != 1) abort_run("stim file ends inside an element list");
					tok_q.push_back(hdr[0]);
				end
				rec_cnt++;
			end else begin
				abort_run($sformatf("unknown record type %s in the stim file", tok));
			end
		end
		$fclose(fd);
	endtask

	// ==============================
	// load and command records
	// ==============================
	task automatic load_matrix();
		int slot;
		int m;
		int n;
		int v;
		int i;
		slot = tok_q.pop_front();
		m    = tok_q.pop_front();
		n    = tok_q.pop_front();
		for (i = 0; i < m * n; i++) begin
			v = tok_q.pop_front();
			@(posedge clk);
			#1;
			ld_valid = 1'b1;
			ld_slot  = slot[0];
			ld_first = (i == 0);   // dims go with the first element
			ld_m     = dim_t'(m);
			ld_n     = dim_t'(n);
			ld_data  = elem_t'(v);
			@(negedge clk);
			while (ld_ready !== 1'b1) @(negedge clk);   // taken at the next rising edge
		end
		@(posedge clk);
		#1;
		ld_valid = 1'b0;
		ld_first = 1'b0;
	endtask

	task automatic run_command();
		int      i;
		int      cnt;
		int      idx;
		int      waits;
		op_e     c_op;
		elem_t   c_scalar;
		status_e exp_st;
		dim_t    exp_m;
		dim_t    exp_n;
		res_t    exp_el[MAX_ELEMS];
		res_t    held;
		logic    stalled;
		c_op     = op_e'(tok_q.pop_front());
		c_scalar = elem_t'(tok_q.pop_front());
		exp_st   = status_e'(tok_q.pop_front());
		exp_m    = dim_t'(tok_q.pop_front());
		exp_n    = dim_t'(tok_q.pop_front());
		cnt      = int'(exp_m) * int'(exp_n);   // 0 on an error record
		for (i = 0; i < cnt; i++) exp_el[i] = res_t'(tok_q.pop_front());
		@(posedge clk);
		#1;
		start  = 1'b1;
		op     = c_op;
		scalar = c_scalar;
		@(posedge clk);
		#1;
		start  = 1'b0;
		op     = OP_TRANSPOSE;   // latched inside, inputs free to move
		scalar = '0;
		@(negedge clk);
		check_flag("busy", busy, 1'b1);
		idx     = 0;
		waits   = 0;
		stalled = 1'b0;
		while (done !== 1'b1) begin
			check_flag("ld_ready", ld_ready, 1'b0);   // operands frozen while busy
			if (res_valid === 1'b1) begin
				if (exp_st != ST_OK) abort_run("result element seen on a command that should fail");
				if (stalled) check_res($sformatf("res_data[%0d] held", idx), res_data, held);
				if (res_ready === 1'b1) begin
					if (idx >= cnt) abort_run("more result elements than expected");
					check_dim("res_m", res_m, exp_m);
					check_dim("res_n", res_n, exp_n);
					check_res($sformatf("res_data[%0d]", idx), res_data, exp_el[idx]);
					check_flag("res_last", res_last, (idx == cnt - 1));
					idx++;
					stalled = 1'b0;
				end else begin
					stalled = 1'b1;   // must not move until ready
					held    = res_data;
				end
			end
			waits++;
			@(negedge clk);
		end
		check_flag("busy", busy, 1'b0);   // falls with done
		check_flag("ld_ready", ld_ready, 1'b1);
		check_status("status", status, exp_st);
		if (exp_st != ST_OK && waits != 1)
			abort_run($sformatf("error status came %0d cycles after start instead of 2", waits + 1));
		if (idx != cnt) abort_run($sformatf("only %0d of %0d result elements arrived", idx, cnt));
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		rst_n    = 1'b0;
		ld_valid = 1'b0;
		ld_slot  = 1'b0;
		ld_first = 1'b0;
		ld_m     = '0;
		ld_n     = '0;
		ld_data  = '0;
		start    = 1'b0;
		op       = OP_TRANSPOSE;
		scalar   = '0;
		parsed   = 1'b0;
		read_stim();
		parsed = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_flag("ld_ready", ld_ready, 1'b0);   // held off one cycle out of reset
		while (tok_q.size() > 0) begin
			if (tok_q.pop_front() == 0) load_matrix();
			else run_command();
		end
		repeat (4) @(posedge clk);
		$display("Simulation completed successfully");
		$finish;
	end

	// res_ready back-pressure, about 3 of 4 cycles ready
	initial begin
		lcg_state = 32'h8c21_e8d9;
		res_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			lcg_state = lcg_next(lcg_state);
			res_ready = (lcg_state[30:29] != 2'b00);
		end
	end

	// watchdog, sized once the record count is known
	initial begin
		longint limit_ns;
		wait (parsed === 1'b1);
		limit_ns = longint'(RST_CYCLES + rec_cnt * WORST_CYC) * CLK_PERIOD;
		#(limit_ns);
		abort_run($sformatf("watchdog expired after %0d ns, the DUT stopped responding", limit_ns));
	end

endmodule

`default_nettype wire

// File: bench/matcalc_stim.txt
# L slot m n, then m*n elements row-major (hex)
# C op scalar status m n, then m*n expected elements row-major (hex), op 0 tr 1 sc 2 add 3 mul
# transpose of a 2x3
L 0 2 3  01 02 03 04 05 06
C 0 00 0 3 2  0001 0004 0002 0005 0003 0006
# scalar by 7, then an illegal scalar
L 0 3 3  01 02 03 04 05 06 07 08 09
C 1 07 0 3 3  0007 000e 0015 001c 0023 002a 0031 0038 003f
C 1 0c 2 0 0
# add of equal sizes, then 2x2 plus 3x2
L 1 3 3  0a 0b 0c 0d 0e 0f 10 11 12
C 2 00 0 3 3  000b 000d 000f 0011 0013 0015 0017 0019 001b
L 0 2 2  01 02 03 04
L 1 3 2  01 02 03 04 05 06
C 2 00 1 0 0
# 2x3 times 3x2
L 0 2 3  01 02 03 04 05 06
L 1 3 2  07 08 09 0a 0b 0c
C 3 00 0 2 2  003a 0040 008b 009a
# 5x5 all nines, each element 405
L 0 5 5  09 09 09 09 09 09 09 09 09 09 09 09 09
         09 09 09 09 09 09 09 09 09 09 09 09
L 1 5 5  09 09 09 09 09 09 09 09 09 09 09 09 09
         09 09 09 09 09 09 09 09 09 09 09 09
C 3 00 0 5 5  0195 0195 0195 0195 0195 0195 0195 0195 0195 0195
              0195 0195 0195 0195 0195 0195 0195 0195 0195 0195
              0195 0195 0195 0195 0195
# smaller reload of A, transpose shows only the new elements
L 0 2 2  21 22 23 24
C 0 00 0 2 2  0021 0023 0022 0024

// File: vlog.f
common/matcalc_pkg.sv
rtl/operand_store.sv
alu/calc_ctrl.sv
alu/elementwise_unit.sv
alu/matmul_unit.sv
alu/result_streamer.sv
rtl/matrix_calc_top.sv
bench/tb_matrix_calc.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_matrix_calc
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
